/* hdl/bus_pkg.sv */
// ****************************************
// Register bus widths and opcode type
// ****************************************

package bus_pkg;

  // Word address and data path
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;

  // Direction of a register bus transfer
  typedef enum logic {
    REG_READ  = 1'b0,
    REG_WRITE = 1'b1
  } reg_op_e;

endpackage : bus_pkg

/* hdl/periph_pkg.sv */
// ****************************************
// Peripheral address map and register offsets
// UART states and boot ROM image
// ****************************************

package periph_pkg;

  // One 4 KB window per peripheral above the base
  localparam logic [bus_pkg::ADDR_WIDTH-1:0] PERIPH_BASE = 32'h2000_0000;
  localparam int PERIPH_WINDOW_BITS = 12;
  localparam int NUM_PERIPH = 3;
  localparam int PERIPH_SEL_WIDTH = 2;

  localparam int SOC_CTRL_IDX = 0;
  localparam int BOOTROM_IDX = 1;
  localparam int UART_IDX = 2;

  // SoC control registers
  localparam logic [PERIPH_WINDOW_BITS-1:0] EXIT_VALID_OFFSET = 12'h000;
  localparam logic [PERIPH_WINDOW_BITS-1:0] EXIT_VALUE_OFFSET = 12'h004;
  localparam logic [PERIPH_WINDOW_BITS-1:0] BOOT_SELECT_OFFSET = 12'h008;
  localparam logic [PERIPH_WINDOW_BITS-1:0] SCRATCH_OFFSET = 12'h00C;

  // UART registers
  localparam logic [PERIPH_WINDOW_BITS-1:0] UART_DIV_OFFSET = 12'h000;
  localparam logic [PERIPH_WINDOW_BITS-1:0] UART_STATUS_OFFSET = 12'h004;
  localparam logic [PERIPH_WINDOW_BITS-1:0] UART_TXDATA_OFFSET = 12'h008;
  localparam int UART_DIV_WIDTH = 16;
  localparam logic [UART_DIV_WIDTH-1:0] UART_DIV_RESET = 16'd15;

  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

  // Boot image, small jump loop plus constants
  localparam int BOOT_ROM_DEPTH = 8;
  localparam logic [bus_pkg::DATA_WIDTH-1:0] BOOT_ROM_WORDS [0:BOOT_ROM_DEPTH-1] = '{
    32'h0000_0297, 32'h0202_8293, 32'h0002_a303, 32'h0003_0067,
    32'h0000_0013, 32'h0000_006f, 32'h5a5a_c3c3, 32'h0bad_f00d
  };

endpackage : periph_pkg

/* hdl/obi_to_reg.sv */
// ****************************************
// OBI slave to register bus bridge
// ****************************************

`timescale 1ns/10ps

module obi_to_reg (
  input  logic                           clk_i,
  input  logic                           rst_n_i,

  input  logic                           obi_req_i,
  input  logic                           obi_we_i,
  input  logic [bus_pkg::ADDR_WIDTH-1:0] obi_addr_i,
  input  logic [bus_pkg::DATA_WIDTH-1:0] obi_wdata_i,
  output logic                           obi_gnt_o,
  output logic                           obi_rvalid_o,
  output logic [bus_pkg::DATA_WIDTH-1:0] obi_rdata_o,
  output logic                           obi_err_o,

  output logic                           reg_valid_o,
  output bus_pkg::reg_op_e               reg_op_o,
  output logic [bus_pkg::ADDR_WIDTH-1:0] reg_addr_o,
  output logic [bus_pkg::DATA_WIDTH-1:0] reg_wdata_o,
  input  logic                           reg_ready_i,
  input  logic [bus_pkg::DATA_WIDTH-1:0] reg_rdata_i,
  input  logic                           reg_error_i
);

  typedef enum logic {
    ST_IDLE,
    ST_ACCESS
  } state_e;

  state_e                         state_q;
  logic                           rvalid_q;
  bus_pkg::reg_op_e               op_q;
  logic [bus_pkg::ADDR_WIDTH-1:0] addr_q;
  logic [bus_pkg::DATA_WIDTH-1:0] wdata_q;
  logic [bus_pkg::DATA_WIDTH-1:0] rdata_q;
  logic                           err_q;
  logic                           gnt;

  assign reg_valid_o = (state_q == ST_ACCESS);
  assign reg_op_o = op_q;
  assign reg_addr_o = addr_q;
  assign reg_wdata_o = wdata_q;

  // Grant when the slave finishes the transfer
  assign gnt = reg_valid_o && reg_ready_i;
  assign obi_gnt_o = gnt;

  assign obi_rvalid_o = rvalid_q;
  assign obi_rdata_o = rdata_q;
  assign obi_err_o = err_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt;
      case (state_q)
        ST_IDLE: if (obi_req_i) state_q <= ST_ACCESS;
        default: if (gnt) state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && obi_req_i) begin
      op_q <= obi_we_i ? bus_pkg::REG_WRITE : bus_pkg::REG_READ;
      addr_q <= obi_addr_i;
      wdata_q <= obi_wdata_i;
    end
    if (gnt) begin
      rdata_q <= reg_rdata_i;
      err_q <= reg_error_i;
    end
  end

endmodule : obi_to_reg

/* hdl/reg_demux.sv */
// ****************************************
// Address decode and register bus demux
// ****************************************

`timescale 1ns/10ps

module reg_demux (
  input  logic                           in_valid_i,
  input  bus_pkg::reg_op_e               in_op_i,
  input  logic [bus_pkg::ADDR_WIDTH-1:0] in_addr_i,
  input  logic [bus_pkg::DATA_WIDTH-1:0] in_wdata_i,
  output logic                           in_ready_o,
  output logic [bus_pkg::DATA_WIDTH-1:0] in_rdata_o,
  output logic                           in_error_o,

  output logic                           out_valid_o [periph_pkg::NUM_PERIPH],
  output bus_pkg::reg_op_e               out_op_o    [periph_pkg::NUM_PERIPH],
  output logic [bus_pkg::ADDR_WIDTH-1:0] out_addr_o  [periph_pkg::NUM_PERIPH],
  output logic [bus_pkg::DATA_WIDTH-1:0] out_wdata_o [periph_pkg::NUM_PERIPH],
  input  logic                           out_ready_i [periph_pkg::NUM_PERIPH],
  input  logic [bus_pkg::DATA_WIDTH-1:0] out_rdata_i [periph_pkg::NUM_PERIPH],
  input  logic                           out_error_i [periph_pkg::NUM_PERIPH]
);

  logic [periph_pkg::PERIPH_SEL_WIDTH-1:0]   sel;
  logic [periph_pkg::PERIPH_WINDOW_BITS-1:0] offset;
  logic                                      base_match;
  logic                                      hit;

  // Window index sits just above the in-window offset
  assign sel = in_addr_i[periph_pkg::PERIPH_WINDOW_BITS +: periph_pkg::PERIPH_SEL_WIDTH];
  assign offset = in_addr_i[periph_pkg::PERIPH_WINDOW_BITS-1:0];
  assign base_match =
    (in_addr_i >> (periph_pkg::PERIPH_WINDOW_BITS + periph_pkg::PERIPH_SEL_WIDTH)) ==
    (periph_pkg::PERIPH_BASE >> (periph_pkg::PERIPH_WINDOW_BITS + periph_pkg::PERIPH_SEL_WIDTH));
  assign hit = base_match && (int'(sel) < periph_pkg::NUM_PERIPH);

  always_comb begin
    for (int i = 0; i < periph_pkg::NUM_PERIPH; i++) begin
      out_valid_o[i] = in_valid_i && hit && (int'(sel) == i);
      out_op_o[i] = in_op_i;
      out_addr_o[i] = '0;
      out_addr_o[i][periph_pkg::PERIPH_WINDOW_BITS-1:0] = offset;
      out_wdata_o[i] = in_wdata_i;
    end
  end

  // Unmapped addresses complete at once with an error
  always_comb begin
    in_ready_o = 1'b1;
    in_rdata_o = '0;
    in_error_o = 1'b1;
    for (int i = 0; i < periph_pkg::NUM_PERIPH; i++) begin
      if (hit && int'(sel) == i) begin
        in_ready_o = out_ready_i[i];
        in_rdata_o = out_rdata_i[i];
        in_error_o = out_error_i[i];
      end
    end
  end

endmodule : reg_demux

/* hdl/soc_ctrl.sv */
// ****************************************
// SoC control registers, exit and boot mirror
// ****************************************

`timescale 1ns/10ps

module soc_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           boot_select_i,

  input  logic                           reg_valid_i,
  input  bus_pkg::reg_op_e               reg_op_i,
  input  logic [bus_pkg::ADDR_WIDTH-1:0] reg_addr_i,
  input  logic [bus_pkg::DATA_WIDTH-1:0] reg_wdata_i,
  output logic                           reg_ready_o,
  output logic [bus_pkg::DATA_WIDTH-1:0] reg_rdata_o,
  output logic                           reg_error_o,

  output logic                           exit_valid_o,
  output logic [bus_pkg::DATA_WIDTH-1:0] exit_value_o
);

  logic [periph_pkg::PERIPH_WINDOW_BITS-1:0] offset;
  logic                                      wr_en;
  logic                                      exit_valid_q;
  logic [bus_pkg::DATA_WIDTH-1:0]            exit_value_q;
  logic [bus_pkg::DATA_WIDTH-1:0]            scratch_q;

  assign offset = reg_addr_i[periph_pkg::PERIPH_WINDOW_BITS-1:0];
  assign wr_en = reg_valid_i && (reg_op_i == bus_pkg::REG_WRITE);

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en) begin
      if (offset == periph_pkg::EXIT_VALID_OFFSET) exit_valid_q <= reg_wdata_i[0];
      if (offset == periph_pkg::EXIT_VALUE_OFFSET) exit_value_q <= reg_wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en && offset == periph_pkg::SCRATCH_OFFSET) scratch_q <= reg_wdata_i;
  end

  // Single-cycle slave, never stalls
  assign reg_ready_o = 1'b1;

  always_comb begin
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    case (offset)
      periph_pkg::EXIT_VALID_OFFSET:  reg_rdata_o[0] = exit_valid_q;
      periph_pkg::EXIT_VALUE_OFFSET:  reg_rdata_o = exit_value_q;
      periph_pkg::BOOT_SELECT_OFFSET: reg_rdata_o[0] = boot_select_i;
      periph_pkg::SCRATCH_OFFSET:     reg_rdata_o = scratch_q;
      default:                        reg_error_o = 1'b1;
    endcase
  end

endmodule : soc_ctrl

/* hdl/boot_rom.sv */
// ****************************************
// Read-only boot ROM slave
// ****************************************

`timescale 1ns/10ps

module boot_rom (
  input  logic                           reg_valid_i,
  input  bus_pkg::reg_op_e               reg_op_i,
  input  logic [bus_pkg::ADDR_WIDTH-1:0] reg_addr_i,
  output logic                           reg_ready_o,
  output logic [bus_pkg::DATA_WIDTH-1:0] reg_rdata_o,
  output logic                           reg_error_o
);

  logic [periph_pkg::PERIPH_WINDOW_BITS-3:0] word_idx;

  assign word_idx = reg_addr_i[periph_pkg::PERIPH_WINDOW_BITS-1:2];

  assign reg_ready_o = 1'b1;
  // ROM is not writable
  assign reg_error_o = reg_valid_i && (reg_op_i == bus_pkg::REG_WRITE);

  always_comb begin
    reg_rdata_o = '0;
    for (int i = 0; i < periph_pkg::BOOT_ROM_DEPTH; i++) begin
      if (int'(word_idx) == i) reg_rdata_o = periph_pkg::BOOT_ROM_WORDS[i];
    end
  end

endmodule : boot_rom

/* hdl/uart_tx.sv */
// ****************************************
// UART transmitter, 8N1, register mapped
// ****************************************

`timescale 1ns/10ps

module uart_tx (
  input  logic                           clk_i,
  input  logic                           rst_n_i,

  input  logic                           reg_valid_i,
  input  bus_pkg::reg_op_e               reg_op_i,
  input  logic [bus_pkg::ADDR_WIDTH-1:0] reg_addr_i,
  input  logic [bus_pkg::DATA_WIDTH-1:0] reg_wdata_i,
  output logic                           reg_ready_o,
  output logic [bus_pkg::DATA_WIDTH-1:0] reg_rdata_o,
  output logic                           reg_error_o,

  output logic                           uart_tx_o,
  output logic                           uart_tx_empty_o
);

  logic [periph_pkg::PERIPH_WINDOW_BITS-1:0] offset;
  logic [periph_pkg::UART_DIV_WIDTH-1:0]     div_q;
  logic [periph_pkg::UART_DIV_WIDTH-1:0]     baud_cnt_q;
  logic [2:0]                                bit_cnt_q;
  logic [7:0]                                shift_q;
  periph_pkg::uart_state_e                   state_q;
  logic                                      wr_en;
  logic                                      tx_wr;
  logic                                      busy;
  logic                                      start;
  logic                                      baud_tick;

  assign offset = reg_addr_i[periph_pkg::PERIPH_WINDOW_BITS-1:0];
  assign wr_en = reg_valid_i && (reg_op_i == bus_pkg::REG_WRITE);
  assign tx_wr = wr_en && (offset == periph_pkg::UART_TXDATA_OFFSET);
  assign busy = (state_q != periph_pkg::UART_IDLE);
  assign start = tx_wr && !busy;
  assign baud_tick = (baud_cnt_q == div_q);

  // Hold off a TXDATA write until the current frame is out
  assign reg_ready_o = !(tx_wr && busy);

  always_comb begin
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    case (offset)
      periph_pkg::UART_DIV_OFFSET:    reg_rdata_o[periph_pkg::UART_DIV_WIDTH-1:0] = div_q;
      periph_pkg::UART_STATUS_OFFSET: reg_rdata_o[0] = busy;
      periph_pkg::UART_TXDATA_OFFSET: reg_rdata_o = '0;
      default:                        reg_error_o = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      div_q <= periph_pkg::UART_DIV_RESET;
      baud_cnt_q <= '0;
    end else begin
      if (wr_en && offset == periph_pkg::UART_DIV_OFFSET) begin
        div_q <= reg_wdata_i[periph_pkg::UART_DIV_WIDTH-1:0];
      end
      if (!busy || baud_tick) baud_cnt_q <= '0;
      else baud_cnt_q <= baud_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= periph_pkg::UART_IDLE;
      bit_cnt_q <= '0;
    end else begin
      case (state_q)
        periph_pkg::UART_IDLE: if (start) state_q <= periph_pkg::UART_START;
        periph_pkg::UART_START: begin
          if (baud_tick) begin
            state_q <= periph_pkg::UART_DATA;
            bit_cnt_q <= '0;
          end
        end
        periph_pkg::UART_DATA: begin
          if (baud_tick) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) state_q <= periph_pkg::UART_STOP;
          end
        end
        default: if (baud_tick) state_q <= periph_pkg::UART_IDLE;
      endcase
    end
  end

  // LSB goes out first
  always_ff @(posedge clk_i) begin
    if (start) shift_q <= reg_wdata_i[7:0];
    else if (state_q == periph_pkg::UART_DATA && baud_tick) shift_q <= shift_q >> 1;
  end

  always_comb begin
    case (state_q)
      periph_pkg::UART_START: uart_tx_o = 1'b0;
      periph_pkg::UART_DATA:  uart_tx_o = shift_q[0];
      default:                uart_tx_o = 1'b1;
    endcase
  end

  assign uart_tx_empty_o = !busy;

endmodule : uart_tx

/* hdl/peripheral_subsystem.sv */
// ****************************************
// Peripheral subsystem top, bridge to slaves
// ****************************************

`timescale 1ns/10ps

module peripheral_subsystem (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           boot_select_i,

  input  logic                           obi_req_i,
  input  logic                           obi_we_i,
  input  logic [bus_pkg::ADDR_WIDTH-1:0] obi_addr_i,
  input  logic [bus_pkg::DATA_WIDTH-1:0] obi_wdata_i,
  output logic                           obi_gnt_o,
  output logic                           obi_rvalid_o,
  output logic [bus_pkg::DATA_WIDTH-1:0] obi_rdata_o,
  output logic                           obi_err_o,

  output logic                           exit_valid_o,
  output logic [bus_pkg::DATA_WIDTH-1:0] exit_value_o,

  output logic                           uart_tx_o,
  output logic                           uart_tx_empty_o
);

  // Bridge to demux
  logic                           reg_valid;
  bus_pkg::reg_op_e               reg_op;
  logic [bus_pkg::ADDR_WIDTH-1:0] reg_addr;
  logic [bus_pkg::DATA_WIDTH-1:0] reg_wdata;
  logic                           reg_ready;
  logic [bus_pkg::DATA_WIDTH-1:0] reg_rdata;
  logic                           reg_error;

  // Demux to slaves
  logic                           slv_valid [periph_pkg::NUM_PERIPH];
  bus_pkg::reg_op_e               slv_op    [periph_pkg::NUM_PERIPH];
  logic [bus_pkg::ADDR_WIDTH-1:0] slv_addr  [periph_pkg::NUM_PERIPH];
  logic [bus_pkg::DATA_WIDTH-1:0] slv_wdata [periph_pkg::NUM_PERIPH];
  logic                           slv_ready [periph_pkg::NUM_PERIPH];
  logic [bus_pkg::DATA_WIDTH-1:0] slv_rdata [periph_pkg::NUM_PERIPH];
  logic                           slv_error [periph_pkg::NUM_PERIPH];

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .rst_n_i,
    .obi_req_i,
    .obi_we_i,
    .obi_addr_i,
    .obi_wdata_i,
    .obi_gnt_o,
    .obi_rvalid_o,
    .obi_rdata_o,
    .obi_err_o,
    .reg_valid_o(reg_valid),
    .reg_op_o   (reg_op),
    .reg_addr_o (reg_addr),
    .reg_wdata_o(reg_wdata),
    .reg_ready_i(reg_ready),
    .reg_rdata_i(reg_rdata),
    .reg_error_i(reg_error)
  );

  reg_demux reg_demux_i (
    .in_valid_i (reg_valid),
    .in_op_i    (reg_op),
    .in_addr_i  (reg_addr),
    .in_wdata_i (reg_wdata),
    .in_ready_o (reg_ready),
    .in_rdata_o (reg_rdata),
    .in_error_o (reg_error),
    .out_valid_o(slv_valid),
    .out_op_o   (slv_op),
    .out_addr_o (slv_addr),
    .out_wdata_o(slv_wdata),
    .out_ready_i(slv_ready),
    .out_rdata_i(slv_rdata),
    .out_error_i(slv_error)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_n_i,
    .boot_select_i,
    .reg_valid_i (slv_valid[periph_pkg::SOC_CTRL_IDX]),
    .reg_op_i    (slv_op[periph_pkg::SOC_CTRL_IDX]),
    .reg_addr_i  (slv_addr[periph_pkg::SOC_CTRL_IDX]),
    .reg_wdata_i (slv_wdata[periph_pkg::SOC_CTRL_IDX]),
    .reg_ready_o (slv_ready[periph_pkg::SOC_CTRL_IDX]),
    .reg_rdata_o (slv_rdata[periph_pkg::SOC_CTRL_IDX]),
    .reg_error_o (slv_error[periph_pkg::SOC_CTRL_IDX]),
    .exit_valid_o,
    .exit_value_o
  );

  boot_rom boot_rom_i (
    .reg_valid_i(slv_valid[periph_pkg::BOOTROM_IDX]),
    .reg_op_i   (slv_op[periph_pkg::BOOTROM_IDX]),
    .reg_addr_i (slv_addr[periph_pkg::BOOTROM_IDX]),
    .reg_ready_o(slv_ready[periph_pkg::BOOTROM_IDX]),
    .reg_rdata_o(slv_rdata[periph_pkg::BOOTROM_IDX]),
    .reg_error_o(slv_error[periph_pkg::BOOTROM_IDX])
  );

  uart_tx uart_tx_i (
    .clk_i,
    .rst_n_i,
    .reg_valid_i(slv_valid[periph_pkg::UART_IDX]),
    .reg_op_i   (slv_op[periph_pkg::UART_IDX]),
    .reg_addr_i (slv_addr[periph_pkg::UART_IDX]),
    .reg_wdata_i(slv_wdata[periph_pkg::UART_IDX]),
    .reg_ready_o(slv_ready[periph_pkg::UART_IDX]),
    .reg_rdata_o(slv_rdata[periph_pkg::UART_IDX]),
    .reg_error_o(slv_error[periph_pkg::UART_IDX]),
    .uart_tx_o,
    .uart_tx_empty_o
  );

endmodule : peripheral_subsystem

/* testbench/peripheral_subsystem_assertions.sv */
// ****************************************
// Bus protocol and UART line assertions
// ****************************************

`timescale 1ns/10ps

module peripheral_subsystem_assertions (
  input logic clk_i,
  input logic rst_n_i,
  input logic obi_req_i,
  input logic obi_gnt_i,
  input logic obi_rvalid_i,
  input logic exit_valid_i,
  input logic uart_tx_i,
  input logic uart_tx_empty_i
);

  // Grant only answers a pending request
  gnt_with_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    obi_gnt_i |-> obi_req_i)
    else $error("obi_gnt_o high while obi_req_i is low");

  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    obi_gnt_i |=> obi_rvalid_i)
    else $error("obi_rvalid_o missing one cycle after obi_gnt_o");

  rvalid_only_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    obi_rvalid_i |-> $past(obi_gnt_i))
    else $error("obi_rvalid_o without a grant in the previous cycle");

  // Idle line level
  line_high_when_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    uart_tx_empty_i |-> uart_tx_i)
    else $error("uart_tx_o low while the transmitter is empty");

  exit_needs_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(exit_valid_i) |-> $past(obi_gnt_i))
    else $error("exit_valid_o rose without a bus grant");

endmodule : peripheral_subsystem_assertions

/* testbench/tb_peripheral_subsystem.sv */
// ****************************************
// Testbench for the peripheral subsystem
// Stimulus table, OBI driver, UART decoder
// ****************************************

`timescale 1ns/10ps

module tb_peripheral_subsystem;

  localparam int BUS_TIMEOUT = 2000;
  localparam int FRAME_TIMEOUT = 2000;
  localparam logic [31:0] RNG_SEED = 32'd37036;

  logic        clk_i;
  logic        rst_n_i;
  logic        boot_select_i;
  logic        obi_req_i;
  logic        obi_we_i;
  logic [31:0] obi_addr_i;
  logic [31:0] obi_wdata_i;
  logic        obi_gnt_o;
  logic        obi_rvalid_o;
  logic [31:0] obi_rdata_o;
  logic        obi_err_o;
  logic        exit_valid_o;
  logic [31:0] exit_value_o;
  logic        uart_tx_o;
  logic        uart_tx_empty_o;

  // Stimulus table, one entry per test
  string       t_name  [$];
  bit          t_bsel  [$];
  bit          t_we    [$];
  logic [31:0] t_addr  [$];
  logic [31:0] t_wdata [$];
  logic [31:0] t_rdata [$];
  bit          t_err   [$];
  bit          t_frame [$];

  logic [31:0] rng_state = RNG_SEED;
  int          uart_div = 15;
  int          frames_armed = 0;
  logic [7:0]  exp_bytes [$];
  string       exp_frame_names [$];
  logic [7:0]  rx_bytes [$];
  int          error_count = 0;
  int          test_count = 0;
  int          fail_count = 0;

  peripheral_subsystem dut (
    .clk_i,
    .rst_n_i,
    .boot_select_i,
    .obi_req_i,
    .obi_we_i,
    .obi_addr_i,
    .obi_wdata_i,
    .obi_gnt_o,
    .obi_rvalid_o,
    .obi_rdata_o,
    .obi_err_o,
    .exit_valid_o,
    .exit_value_o,
    .uart_tx_o,
    .uart_tx_empty_o
  );

  bind peripheral_subsystem peripheral_subsystem_assertions assertions_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .obi_req_i      (obi_req_i),
    .obi_gnt_i      (obi_gnt_o),
    .obi_rvalid_i   (obi_rvalid_o),
    .exit_valid_i   (exit_valid_o),
    .uart_tx_i      (uart_tx_o),
    .uart_tx_empty_i(uart_tx_empty_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Window k starts k * 4 KB above the base
  function automatic logic [31:0] window_addr(input int idx, input logic [11:0] offset);
    logic [31:0] base;
    base = periph_pkg::PERIPH_BASE + (32'(idx) << periph_pkg::PERIPH_WINDOW_BITS);
    return base + {20'h0, offset};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("FAIL %s", name);
    end
  endtask

  task automatic add_test(input string name, input bit bsel, input bit we,
                          input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [31:0] exp_rdata, input bit exp_err, input bit frame);
    t_name.push_back(name);
    t_bsel.push_back(bsel);
    t_we.push_back(we);
    t_addr.push_back(addr);
    t_wdata.push_back(wdata);
    t_rdata.push_back(exp_rdata);
    t_err.push_back(exp_err);
    t_frame.push_back(frame);
  endtask

  task automatic build_table();
    logic [31:0] soc;
    logic [31:0] rom;
    logic [31:0] uart;
    soc = window_addr(periph_pkg::SOC_CTRL_IDX, 12'h0);
    rom = window_addr(periph_pkg::BOOTROM_IDX, 12'h0);
    uart = window_addr(periph_pkg::UART_IDX, 12'h0);
    for (int i = 0; i < periph_pkg::BOOT_ROM_DEPTH; i++) begin
      add_test($sformatf("rom_word_%0d", i), 1'b0, 1'b0, rom + 32'(4 * i), 32'h0,
               periph_pkg::BOOT_ROM_WORDS[i], 1'b0, 1'b0);
    end
    add_test("rom_beyond_table", 1'b0, 1'b0, rom + 32'(4 * periph_pkg::BOOT_ROM_DEPTH),
             32'h0, 32'h0, 1'b0, 1'b0);
    add_test("rom_write", 1'b0, 1'b1, rom, 32'hdead_beef, 32'h0, 1'b1, 1'b0);
    rng_state = xorshift32(rng_state);
    add_test("scratch_write", 1'b0, 1'b1, soc + 32'(periph_pkg::SCRATCH_OFFSET), rng_state,
             32'h0, 1'b0, 1'b0);
    add_test("scratch_read", 1'b0, 1'b0, soc + 32'(periph_pkg::SCRATCH_OFFSET), 32'h0,
             rng_state, 1'b0, 1'b0);
    add_test("boot_select_low", 1'b0, 1'b0, soc + 32'(periph_pkg::BOOT_SELECT_OFFSET),
             32'h0, 32'h0, 1'b0, 1'b0);
    add_test("boot_select_high", 1'b1, 1'b0, soc + 32'(periph_pkg::BOOT_SELECT_OFFSET),
             32'h0, 32'h1, 1'b0, 1'b0);
    rng_state = xorshift32(rng_state);
    add_test("exit_value_write", 1'b0, 1'b1, soc + 32'(periph_pkg::EXIT_VALUE_OFFSET),
             rng_state, 32'h0, 1'b0, 1'b0);
    add_test("exit_valid_write", 1'b0, 1'b1, soc + 32'(periph_pkg::EXIT_VALID_OFFSET),
             32'h1, 32'h0, 1'b0, 1'b0);
    add_test("exit_value_read", 1'b0, 1'b0, soc + 32'(periph_pkg::EXIT_VALUE_OFFSET),
             32'h0, rng_state, 1'b0, 1'b0);
    add_test("soc_bad_offset", 1'b0, 1'b0, soc + 32'h10, 32'h0, 32'h0, 1'b1, 1'b0);
    add_test("unmapped_window", 1'b0, 1'b0, window_addr(periph_pkg::NUM_PERIPH, 12'h0),
             32'h0, 32'h0, 1'b1, 1'b0);
    add_test("unmapped_base", 1'b0, 1'b0, 32'h1000_0000, 32'h0, 32'h0, 1'b1, 1'b0);
    add_test("uart_bad_offset", 1'b0, 1'b0, uart + 32'h0c, 32'h0, 32'h0, 1'b1, 1'b0);
    add_test("uart_div_reset", 1'b0, 1'b0, uart + 32'(periph_pkg::UART_DIV_OFFSET),
             32'h0, 32'd15, 1'b0, 1'b0);
    add_test("uart_div_write", 1'b0, 1'b1, uart + 32'(periph_pkg::UART_DIV_OFFSET),
             32'd7, 32'h0, 1'b0, 1'b0);
    add_test("uart_div_read", 1'b0, 1'b0, uart + 32'(periph_pkg::UART_DIV_OFFSET),
             32'h0, 32'd7, 1'b0, 1'b0);
    add_test("uart_status_idle", 1'b0, 1'b0, uart + 32'(periph_pkg::UART_STATUS_OFFSET),
             32'h0, 32'h0, 1'b0, 1'b0);
    rng_state = xorshift32(rng_state);
    add_test("uart_tx_first", 1'b0, 1'b1, uart + 32'(periph_pkg::UART_TXDATA_OFFSET),
             rng_state, 32'h0, 1'b0, 1'b1);
    add_test("uart_status_busy", 1'b0, 1'b0, uart + 32'(periph_pkg::UART_STATUS_OFFSET),
             32'h0, 32'h1, 1'b0, 1'b0);
    // Issued mid frame, so the bridge stalls here
    rng_state = xorshift32(rng_state);
    add_test("uart_tx_stalled", 1'b0, 1'b1, uart + 32'(periph_pkg::UART_TXDATA_OFFSET),
             rng_state, 32'h0, 1'b0, 1'b1);
    add_test("uart_status_busy_again", 1'b0, 1'b0,
             uart + 32'(periph_pkg::UART_STATUS_OFFSET), 32'h0, 32'h1, 1'b0, 1'b0);
  endtask

  // Called on a falling edge; gnt and rvalid hold steady over the low phase
  task automatic bus_access(input bit we, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output bit ok);
    int cycles;
    ok = 1'b0;
    rdata = 32'h0;
    err = 1'b0;
    obi_req_i = 1'b1;
    obi_we_i = we;
    obi_addr_i = addr;
    obi_wdata_i = wdata;
    cycles = 0;
    while (obi_gnt_o !== 1'b1 && cycles < BUS_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (obi_gnt_o !== 1'b1) begin
      obi_req_i = 1'b0;
      $display("ERROR: no grant within %0d cycles at address 0x%08h", BUS_TIMEOUT, addr);
      return;
    end
    @(negedge clk_i);
    obi_req_i = 1'b0;
    cycles = 0;
    while (obi_rvalid_o !== 1'b1 && cycles < BUS_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (obi_rvalid_o !== 1'b1) begin
      $display("ERROR: no rvalid within %0d cycles at address 0x%08h", BUS_TIMEOUT, addr);
      return;
    end
    rdata = obi_rdata_o;
    err = obi_err_o;
    ok = 1'b1;
  endtask

  task automatic receive_frame(output logic [7:0] data, output bit ok);
    int cycles;
    int bit_len;
    logic [7:0] shift;
    ok = 1'b0;
    data = 8'h0;
    shift = 8'h0;
    bit_len = uart_div + 1;
    cycles = 0;
    while (uart_tx_o !== 1'b0 && cycles < FRAME_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (uart_tx_o !== 1'b0) begin
      $display("ERROR: no UART start bit within %0d cycles", FRAME_TIMEOUT);
      return;
    end
    // Middle of the start bit
    repeat (bit_len / 2) @(negedge clk_i);
    if (uart_tx_o !== 1'b0) begin
      $display("ERROR: UART start bit shorter than half a bit time");
      return;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (bit_len) @(negedge clk_i);
      shift[i] = uart_tx_o;
    end
    repeat (bit_len) @(negedge clk_i);
    if (uart_tx_o !== 1'b1) begin
      $display("ERROR: UART stop bit is not high");
      return;
    end
    data = shift;
    ok = 1'b1;
  endtask

  initial begin : uart_monitor
    logic [7:0] byte_seen;
    bit         ok;
    forever begin
      @(negedge clk_i);
      if (frames_armed > 0) begin
        frames_armed--;
        receive_frame(byte_seen, ok);
        if (ok) rx_bytes.push_back(byte_seen);
        else error_count++;
      end
    end
  end

  initial begin : main_flow
    logic [31:0] rdata;
    logic        err;
    bit          ok;
    int          errs_before;
    int          cycles;
    bit          exit_valid_exp;
    logic [31:0] exit_value_exp;
    logic [31:0] wdata;
    rst_n_i = 1'b0;
    boot_select_i = 1'b0;
    obi_req_i = 1'b0;
    obi_we_i = 1'b0;
    obi_addr_i = 32'h0;
    obi_wdata_i = 32'h0;
    exit_valid_exp = 1'b0;
    exit_value_exp = 32'h0;
    build_table();
    repeat (5) @(negedge clk_i);

    errs_before = error_count;
    check_value("reset obi_gnt_o", 32'h0, {31'h0, obi_gnt_o});
    check_value("reset obi_rvalid_o", 32'h0, {31'h0, obi_rvalid_o});
    check_value("reset exit_valid_o", 32'h0, {31'h0, exit_valid_o});
    check_value("reset exit_value_o", 32'h0, exit_value_o);
    check_value("reset uart_tx_o", 32'h1, {31'h0, uart_tx_o});
    check_value("reset uart_tx_empty_o", 32'h1, {31'h0, uart_tx_empty_o});
    report_test("reset_values", errs_before);
    rst_n_i = 1'b1;
    @(negedge clk_i);

    for (int t = 0; t < t_name.size(); t++) begin
      errs_before = error_count;
      wdata = t_wdata[t];
      boot_select_i = t_bsel[t];
      if (t_frame[t]) begin
        exp_bytes.push_back(wdata[7:0]);
        exp_frame_names.push_back(t_name[t]);
        frames_armed++;
      end
      bus_access(t_we[t], t_addr[t], wdata, rdata, err, ok);
      if (!ok) begin
        $display("ERROR: %s did not complete on the bus", t_name[t]);
        error_count++;
        report_test(t_name[t], errs_before);
        break;
      end
      if (t_we[t] && !t_err[t]) begin
        if (t_addr[t] == window_addr(periph_pkg::SOC_CTRL_IDX, periph_pkg::EXIT_VALID_OFFSET))
          exit_valid_exp = wdata[0];
        if (t_addr[t] == window_addr(periph_pkg::SOC_CTRL_IDX, periph_pkg::EXIT_VALUE_OFFSET))
          exit_value_exp = wdata;
        if (t_addr[t] == window_addr(periph_pkg::UART_IDX, periph_pkg::UART_DIV_OFFSET))
          uart_div = int'(wdata[15:0]);
      end
      if (!t_we[t]) check_value($sformatf("%s rdata", t_name[t]), t_rdata[t], rdata);
      check_value($sformatf("%s err", t_name[t]), {31'h0, t_err[t]}, {31'h0, err});
      check_value($sformatf("%s exit_valid_o", t_name[t]), {31'h0, exit_valid_exp},
                  {31'h0, exit_valid_o});
      check_value($sformatf("%s exit_value_o", t_name[t]), exit_value_exp, exit_value_o);
      report_test(t_name[t], errs_before);
    end

    // Let the pending UART frames finish
    cycles = 0;
    while (rx_bytes.size() < exp_bytes.size() && cycles < 2 * FRAME_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    for (int i = 0; i < exp_bytes.size(); i++) begin
      errs_before = error_count;
      if (i < rx_bytes.size()) begin
        check_value($sformatf("%s frame", exp_frame_names[i]), {24'h0, exp_bytes[i]},
                    {24'h0, rx_bytes[i]});
      end else begin
        $display("ERROR: no UART frame was decoded for %s", exp_frame_names[i]);
        error_count++;
      end
      report_test($sformatf("%s_frame", exp_frame_names[i]), errs_before);
    end

    $display("Summary: %0d tests, %0d failed, %0d errors", test_count, fail_count,
             error_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_peripheral_subsystem

/* tb.f */
hdl/bus_pkg.sv
hdl/periph_pkg.sv
hdl/obi_to_reg.sv
hdl/reg_demux.sv
hdl/soc_ctrl.sv
hdl/boot_rom.sv
hdl/uart_tx.sv
hdl/peripheral_subsystem.sv
testbench/peripheral_subsystem_assertions.sv
testbench/tb_peripheral_subsystem.sv

/* run.sh */
#!/bin/sh
# Compile the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f tb.f \
  --top-module tb_peripheral_subsystem -o tb_peripheral_subsystem
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tb_peripheral_subsystem > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
